/* Bender.yml */
package:
  name: gb_bus

export_include_dirs:
  - hw

sources:
  - files:
      - hw/gb_pkg.sv
      - hw/gb_bus_if.sv
      - hw/gb_cpu_port.sv
      - hw/gb_sys_regs.sv
      - hw/gb_irq_ctrl.sv
      - hw/gb_int_ram.sv
      - hw/gb_ext_bus.sv
      - hw/gb_bus_top.sv
  - target: simulation
    files:
      - bench/tb_gb_bus.sv

/* all.f */
+incdir+hw
hw/gb_pkg.sv
hw/gb_bus_if.sv
hw/gb_cpu_port.sv
hw/gb_sys_regs.sv
hw/gb_irq_ctrl.sv
hw/gb_int_ram.sv
hw/gb_ext_bus.sv
hw/gb_bus_top.sv
bench/tb_gb_bus.sv

/* bench/tb_gb_bus.sv */
// testbench for gb_bus_top in cgb mode, ce and ce_2x tied high
// bus tasks set expected values, the concurrent assertions below compare them
`timescale 1ns/100ps
`include "gb_defines.svh"

module tb_gb_bus;

	localparam int unsigned SEED       = 32'hc922;
	localparam int          MAX_CYCLES = 4000; // run needs a few hundred cycles

	logic clk_sys = 1'b0;
	logic reset_ss, ce_i, ce_2x_i, is_gbc_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_wdata_i, cpu_rdata_o, cart_di_o, cart_do_i;
	logic cpu_rd_n_i, cpu_wr_n_i, cpu_iorq_n_i, cpu_m1_n_i, cpu_stop_i, cpu_irq_n_o;
	logic vblank_irq_i, lcd_irq_i, timer_irq_i, serial_irq_i;
	logic [3:0]  joy_din_i;
	logic [1:0]  joy_p54_o;
	logic [14:0] cart_addr_o;
	logic cart_a15_o, cart_rd_o, cart_wr_o, cart_oe_i, ncs_o;
	logic speed_o, vram_bank_o, boot_rom_en_o;

	// expected values, valid while the matching chk flag is high
	logic        chk_rd = 1'b0;
	logic        chk_cart = 1'b0; // cart pins during a read
	logic        chk_wr = 1'b0;   // first tick of a write
	logic        chk_stat = 1'b0;
	logic        chk_io = 1'b0;
	logic [7:0]  exp_rdata, rd_mask, exp_wdata;
	logic [14:0] exp_caddr;
	logic        exp_ncs, exp_a15, exp_cart_rd, exp_cart_wr;
	logic        exp_boot, exp_irq_n, exp_speed, exp_vbk;
	logic [1:0]  exp_p54;
	int          cycles = 0;

	always #5 clk_sys = ~clk_sys; // 10 ns period

	gb_bus_top uut (.*);

	// helpers --------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// rst target of the lowest pending source
	function automatic logic [7:0] vector_of(input logic [4:0] pending);
		if (pending[0])
			return 8'h40; // vblank
		else if (pending[1])
			return 8'h48; // lcd stat
		else if (pending[2])
			return 8'h50; // timer
		else if (pending[3])
			return 8'h58; // serial
		else if (pending[4])
			return 8'h60; // joypad
		else
			return 8'h00;
	endfunction

	// rom and cart ram live on the cartridge
	function automatic logic is_cart_area(input logic [15:0] addr);
		return (addr < 16'h8000) || ((addr >= 16'ha000) && (addr <= 16'hbfff));
	endfunction

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cpu_addr_i  = addr;
		cpu_wdata_i = data;
		cpu_wr_n_i  = 1'b0; // low for two cycles
		exp_cart_wr = is_cart_area(addr);
		exp_wdata   = data;
		chk_wr      = 1'b1; // first low tick carries the write
		@(negedge clk_sys);
		chk_wr     = 1'b0;
		@(negedge clk_sys);
		cpu_wr_n_i = 1'b1;
	endtask

	// only bits set in mask are compared, ncs and cart pins always checked
	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp,
			input logic [7:0] mask);
		@(negedge clk_sys);
		cpu_addr_i  = addr;
		cpu_rd_n_i  = 1'b0;
		exp_rdata   = exp & mask;
		rd_mask     = mask;
		exp_ncs     = !((addr >= 16'ha000) && (addr <= 16'hfdff)); // cram and wram
		exp_a15     = addr[15]; // no read here falls in the boot rom area
		exp_cart_rd = is_cart_area(addr);
		exp_caddr   = addr[14:0];
		repeat (2) @(negedge clk_sys);
		chk_rd   = 1'b1;
		chk_cart = 1'b1;
		@(negedge clk_sys);
		chk_rd     = 1'b0;
		chk_cart   = 1'b0;
		cpu_rd_n_i = 1'b1;
	endtask

	// iorq and m1 low together, vector on the data bus
	task automatic ack_check(input logic [7:0] vec);
		@(negedge clk_sys);
		cpu_iorq_n_i = 1'b0;
		cpu_m1_n_i   = 1'b0;
		exp_rdata    = vec;
		rd_mask      = 8'hff;
		@(negedge clk_sys);
		chk_rd = 1'b1;
		@(negedge clk_sys);
		chk_rd       = 1'b0;
		cpu_iorq_n_i = 1'b1; // release, flag clears on the next tick
		cpu_m1_n_i   = 1'b1;
	endtask

	task automatic expect_status(input logic boot, input logic irq_n, input logic speed);
		@(negedge clk_sys);
		exp_boot  = boot;
		exp_irq_n = irq_n;
		exp_speed = speed;
		chk_stat  = 1'b1;
		@(negedge clk_sys);
		chk_stat = 1'b0;
	endtask

	// vram bank and joypad select pins
	task automatic expect_io(input logic vbk, input logic [1:0] p54);
		@(negedge clk_sys);
		exp_vbk = vbk;
		exp_p54 = p54;
		chk_io  = 1'b1;
		@(negedge clk_sys);
		chk_io = 1'b0;
	endtask

	// timer and serial one cycle high, joypad line 0 falls
	task automatic pulse_sources();
		@(negedge clk_sys);
		timer_irq_i  = 1'b1;
		serial_irq_i = 1'b1;
		joy_din_i    = 4'he;
		@(negedge clk_sys);
		timer_irq_i  = 1'b0;
		serial_irq_i = 1'b0;
		@(negedge clk_sys);
		joy_din_i = 4'hf; // rising joy edge sets nothing
	endtask

	// checks --------------------
	a_rdata: assert property (@(posedge clk_sys) chk_rd |-> ((cpu_rdata_o & rd_mask) == exp_rdata))
		else abort_run($sformatf("Fail at %0t: cpu_rdata_o = %h (mask %h), expected %h",
			$time, $sampled(cpu_rdata_o), rd_mask, exp_rdata));
	a_ncs: assert property (@(posedge clk_sys) chk_cart |-> (ncs_o == exp_ncs))
		else abort_run($sformatf("Fail at %0t: ncs_o = %b, expected %b at address %h",
			$time, $sampled(ncs_o), exp_ncs, cpu_addr_i));
	a_a15: assert property (@(posedge clk_sys) chk_cart |-> (cart_a15_o == exp_a15))
		else abort_run($sformatf("Fail at %0t: cart_a15_o = %b, expected %b at address %h",
			$time, $sampled(cart_a15_o), exp_a15, cpu_addr_i));
	a_cart_rd: assert property (@(posedge clk_sys) chk_cart |-> (cart_rd_o == exp_cart_rd))
		else abort_run($sformatf("Fail at %0t: cart_rd_o = %b, expected %b at address %h",
			$time, $sampled(cart_rd_o), exp_cart_rd, cpu_addr_i));
	a_cart_addr: assert property (@(posedge clk_sys) chk_cart |-> (cart_addr_o == exp_caddr))
		else abort_run($sformatf("Fail at %0t: cart_addr_o = %h, expected %h",
			$time, $sampled(cart_addr_o), exp_caddr));
	a_cart_wr: assert property (@(posedge clk_sys) chk_wr |-> (cart_wr_o == exp_cart_wr))
		else abort_run($sformatf("Fail at %0t: cart_wr_o = %b, expected %b at address %h",
			$time, $sampled(cart_wr_o), exp_cart_wr, cpu_addr_i));
	a_cart_di: assert property (@(posedge clk_sys)
		(chk_wr && exp_cart_wr) |-> (cart_di_o == exp_wdata))
		else abort_run($sformatf("Fail at %0t: cart_di_o = %h, expected %h",
			$time, $sampled(cart_di_o), exp_wdata));
	a_boot: assert property (@(posedge clk_sys) chk_stat |-> (boot_rom_en_o == exp_boot))
		else abort_run($sformatf("Fail at %0t: boot_rom_en_o = %b, expected %b",
			$time, $sampled(boot_rom_en_o), exp_boot));
	a_irq_n: assert property (@(posedge clk_sys) chk_stat |-> (cpu_irq_n_o == exp_irq_n))
		else abort_run($sformatf("Fail at %0t: cpu_irq_n_o = %b, expected %b",
			$time, $sampled(cpu_irq_n_o), exp_irq_n));
	a_speed: assert property (@(posedge clk_sys) chk_stat |-> (speed_o == exp_speed))
		else abort_run($sformatf("Fail at %0t: speed_o = %b, expected %b",
			$time, $sampled(speed_o), exp_speed));
	a_vbk: assert property (@(posedge clk_sys) chk_io |-> (vram_bank_o == exp_vbk))
		else abort_run($sformatf("Fail at %0t: vram_bank_o = %b, expected %b",
			$time, $sampled(vram_bank_o), exp_vbk));
	a_p54: assert property (@(posedge clk_sys) chk_io |-> (joy_p54_o == exp_p54))
		else abort_run($sformatf("Fail at %0t: joy_p54_o = %b, expected %b",
			$time, $sampled(joy_p54_o), exp_p54));

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("timeout: run still busy after %0d cycles", MAX_CYCLES));
	end

	// stimulus --------------------
	initial begin
		logic [7:0] spare [0:3];
		logic [7:0] d0, d1, d2, d5, ob, v, cw;
		logic [4:0] exp_if;
		int unsigned seed_ret;

		seed_ret = $urandom(SEED); // seeds the generator once
		reset_ss = 1'b1;
		ce_i = 1'b1;
		ce_2x_i = 1'b1;
		is_gbc_i = 1'b1;
		cpu_addr_i = 16'h0000;
		cpu_wdata_i = 8'h00;
		cpu_rd_n_i = 1'b1;
		cpu_wr_n_i = 1'b1;
		cpu_iorq_n_i = 1'b1;
		cpu_m1_n_i = 1'b1;
		cpu_stop_i = 1'b0;
		{vblank_irq_i, lcd_irq_i, timer_irq_i, serial_irq_i} = 4'b0000;
		joy_din_i = 4'hf; // lines idle high
		cart_do_i = 8'h00;
		cart_oe_i = 1'b0;
		repeat (8) @(negedge clk_sys);
		reset_ss = 1'b0;

		// spare registers, ff75 keeps bits 6:4 only
		expect_status(1'b1, 1'b1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			spare[i] = 8'($urandom);
			bus_write(`GB_REG_FF72 + 16'(i), spare[i]);
		end
		for (int i = 0; i < 3; i++)
			read_check(`GB_REG_FF72 + 16'(i), spare[i], 8'hff);
		read_check(`GB_REG_FF75, spare[3] | 8'h8f, 8'hff);

		// vram bank and joypad select
		bus_write(`GB_REG_VBK, 8'h01);
		bus_write(`GB_REG_JOYP, 8'h20); // p15 high, p14 low
		expect_io(1'b1, 2'b10);
		read_check(`GB_REG_JOYP, 8'hef, 8'hff); // no button pressed
		bus_write(`GB_REG_VBK, 8'h00);
		bus_write(`GB_REG_JOYP, 8'h10);
		expect_io(1'b0, 2'b01);
		read_check(`GB_REG_VBK, 8'hfe, 8'hff);

		// banked wram, svbk 0 acts as 1, c000 always bank 0
		d0 = 8'($urandom);
		d1 = 8'($urandom);
		d2 = 8'($urandom);
		d5 = 8'($urandom);
		bus_write(`GB_REG_SVBK, 8'h02);
		bus_write(16'hd000, d2);
		bus_write(`GB_REG_SVBK, 8'h05);
		bus_write(16'hd000, d5);
		read_check(16'hd000, d5, 8'hff);
		bus_write(`GB_REG_SVBK, 8'h02);
		read_check(16'hd000, d2, 8'hff);
		bus_write(`GB_REG_SVBK, 8'h00);
		bus_write(16'hd000, d1);
		bus_write(`GB_REG_SVBK, 8'h01);
		read_check(16'hd000, d1, 8'hff);
		bus_write(`GB_REG_SVBK, 8'h03);
		bus_write(16'hc000, d0);
		bus_write(`GB_REG_SVBK, 8'h06);
		read_check(16'hc000, d0, 8'hff);

		// interrupts, all enabled, served lowest bit first
		bus_write(`GB_REG_IE, 8'h1f);
		pulse_sources();
		exp_if = 5'b11100; // timer, serial, joypad
		read_check(`GB_REG_IF, {3'b111, exp_if}, 8'hff);
		expect_status(1'b1, 1'b0, 1'b0);
		while (exp_if != 5'b00000) begin
			ack_check(vector_of(exp_if));
			exp_if = exp_if & (exp_if - 5'd1); // served bit gone
			read_check(`GB_REG_IF, {3'b111, exp_if}, 8'hff);
		end
		expect_status(1'b1, 1'b1, 1'b0);

		// speed switch armed by key1, taken during stop
		bus_write(`GB_REG_KEY1, 8'h01);
		read_check(`GB_REG_KEY1, 8'h01, 8'h01);
		@(negedge clk_sys);
		cpu_stop_i = 1'b1;
		@(negedge clk_sys);
		cpu_stop_i = 1'b0;
		expect_status(1'b1, 1'b1, 1'b1);
		read_check(`GB_REG_KEY1, 8'h80, 8'h81); // speed up, prepare gone

		// cart ram write, byte goes out on the data pins
		cw = 8'($urandom);
		bus_write(16'ha000, cw);

		// open bus holds the rom byte, then floats to ff
		ob = 8'($urandom);
		cart_do_i = ob;
		cart_oe_i = 1'b1;
		read_check(16'h4123, ob, 8'hff);
		cart_oe_i = 1'b0;
		read_check(16'ha000, ob, 8'hff);
		repeat (6) @(negedge clk_sys);
		read_check(16'ha000, 8'hff, 8'hff);
		read_check(16'hfe00, 8'hff, 8'hff); // first address past the ncs window, unmapped

		// boot disable, key0 locked afterwards so cgb mode stays
		v = 8'($urandom);
		bus_write(`GB_REG_FF74, v);
		bus_write(`GB_REG_BOOT, 8'h11);
		expect_status(1'b0, 1'b1, 1'b1);
		bus_write(`GB_REG_KEY0, 8'h04); // would select dmg mode
		read_check(`GB_REG_FF74, v, 8'hff);
		read_check(`GB_REG_SVBK, 8'h06, 8'h07);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* hw/gb_bus_if.sv */
// cpu side bus inside the glue, driven by the cpu port, read by all devices
`timescale 1ns/100ps

interface gb_bus_if import gb_pkg::*; ();

	gb_addr_t addr;
	gb_data_t wdata;
	gb_sel_t  sel;      // decoded selects, mode already applied
	logic     wr_stb;   // one clock per cpu write
	logic     rd;       // read strobe, active high
	logic     ce_cpu;   // cpu clock enable
	logic     is_gbc;   // cgb hardware
	logic     cgb_mode; // cgb features visible to software

	modport host (output addr, wdata, sel, wr_stb, rd, ce_cpu, is_gbc, cgb_mode);
	modport dev  (input  addr, wdata, sel, wr_stb, rd, ce_cpu, is_gbc, cgb_mode);

endinterface

/* hw/gb_bus_top.sv */
// system bus glue top: cpu port, control registers, interrupts, internal ram
// and the cartridge bus, joined by the internal cpu bus
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_bus_top import gb_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic                       ce_i,
	input  logic                       ce_2x_i,
	input  logic                       is_gbc_i,
	input  gb_addr_t                   cpu_addr_i,
	input  gb_data_t                   cpu_wdata_i,
	output gb_data_t                   cpu_rdata_o,
	input  logic                       cpu_rd_n_i,
	input  logic                       cpu_wr_n_i,
	input  logic                       cpu_iorq_n_i,
	input  logic                       cpu_m1_n_i,
	input  logic                       cpu_stop_i,
	output logic                       cpu_irq_n_o,
	input  logic                       vblank_irq_i,
	input  logic                       lcd_irq_i,
	input  logic                       timer_irq_i,
	input  logic                       serial_irq_i,
	input  logic [3:0]                 joy_din_i,
	output logic [1:0]                 joy_p54_o,
	output logic [`GB_CART_ADDR_W-1:0] cart_addr_o,
	output logic                       cart_a15_o,
	output logic                       cart_rd_o,
	output logic                       cart_wr_o,
	output gb_data_t                   cart_di_o,
	input  gb_data_t                   cart_do_i,
	input  logic                       cart_oe_i,
	output logic                       ncs_o,
	output logic                       speed_o,
	output logic                       vram_bank_o,
	output logic                       boot_rom_en_o
);

	gb_bus_if bus ();

	logic       cgb_mode;
	wram_bank_t wram_bank;
	logic       irq_ack;
	gb_data_t   irq_vec;
	gb_data_t   irq_rdata;
	gb_data_t   regs_rdata;
	gb_data_t   ram_rdata;
	gb_data_t   ext_rdata;
	logic       dmg_wram_we;    // dmg work ram write from the cart bus
	gb_data_t   dmg_wram_rdata;

	gb_cpu_port u_cpu_port (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_i(ce_i), .ce_2x_i(ce_2x_i),
		.is_gbc_i(is_gbc_i), .cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i),
		.cpu_rd_n_i(cpu_rd_n_i), .cpu_wr_n_i(cpu_wr_n_i), .speed_i(speed_o),
		.boot_rom_en_i(boot_rom_en_o), .cgb_mode_i(cgb_mode), .irq_ack_i(irq_ack),
		.irq_vec_i(irq_vec), .irq_rdata_i(irq_rdata), .regs_rdata_i(regs_rdata),
		.ram_rdata_i(ram_rdata), .ext_rdata_i(ext_rdata), .cpu_rdata_o(cpu_rdata_o),
		.bus(bus.host)
	);

	gb_sys_regs u_sys_regs (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .bus(bus.dev), .ce_2x_i(ce_2x_i),
		.cpu_stop_i(cpu_stop_i), .joy_din_i(joy_din_i), .rdata_o(regs_rdata),
		.speed_o(speed_o), .boot_rom_en_o(boot_rom_en_o), .cgb_mode_o(cgb_mode),
		.wram_bank_o(wram_bank), .vram_bank_o(vram_bank_o), .joy_p54_o(joy_p54_o)
	);

	// joypad slot of irq_src stays low, its edge comes from the joy lines
	gb_irq_ctrl u_irq_ctrl (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .bus(bus.dev),
		.cpu_iorq_n_i(cpu_iorq_n_i), .cpu_m1_n_i(cpu_m1_n_i),
		.irq_src_i({1'b0, serial_irq_i, timer_irq_i, lcd_irq_i, vblank_irq_i}),
		.joy_din_i(joy_din_i), .irq_ack_o(irq_ack), .irq_vec_o(irq_vec),
		.rdata_o(irq_rdata), .cpu_irq_n_o(cpu_irq_n_o)
	);

	gb_int_ram u_int_ram (
		.clk_sys(clk_sys), .bus(bus.dev), .wram_bank_i(wram_bank),
		.dmg_wram_we_i(dmg_wram_we), .rdata_o(ram_rdata),
		.dmg_wram_rdata_o(dmg_wram_rdata)
	);

	gb_ext_bus u_ext_bus (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_i(ce_i), .bus(bus.dev),
		.boot_rom_en_i(boot_rom_en_o), .dmg_wram_rdata_i(dmg_wram_rdata),
		.cart_do_i(cart_do_i), .cart_oe_i(cart_oe_i), .cart_addr_o(cart_addr_o),
		.cart_a15_o(cart_a15_o), .cart_rd_o(cart_rd_o), .cart_wr_o(cart_wr_o),
		.cart_di_o(cart_di_o), .ncs_o(ncs_o), .dmg_wram_we_o(dmg_wram_we),
		.rdata_o(ext_rdata)
	);

endmodule

/* hw/gb_cpu_port.sv */
// cpu facing side of the glue: clock enable, write edge detect,
// memory map decode and the read data mux back to the cpu
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_cpu_port import gb_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset_ss,
	input  logic     ce_i,
	input  logic     ce_2x_i,
	input  logic     is_gbc_i,
	input  gb_addr_t cpu_addr_i,
	input  gb_data_t cpu_wdata_i,
	input  logic     cpu_rd_n_i,
	input  logic     cpu_wr_n_i,
	input  logic     speed_i,       // double speed
	input  logic     boot_rom_en_i,
	input  logic     cgb_mode_i,
	input  logic     irq_ack_i,
	input  gb_data_t irq_vec_i,
	input  gb_data_t irq_rdata_i,   // if or ie
	input  gb_data_t regs_rdata_i,
	input  gb_data_t ram_rdata_i,
	input  gb_data_t ext_rdata_i,
	output gb_data_t cpu_rdata_o,
	gb_bus_if.host   bus
);

	logic ce_cpu;
	logic old_wr_n;  // write strobe at the last cpu tick
	logic rom_hit;
	logic cram_hit;
	logic wram_hit;
	logic regs_hit;  // anything owned by gb_sys_regs

	assign ce_cpu = speed_i ? ce_2x_i : ce_i;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			old_wr_n <= 1'b1; // strobe idles high
		end else if (ce_cpu) begin
			old_wr_n <= cpu_wr_n_i;
		end
	end

	assign bus.ce_cpu   = ce_cpu;
	assign bus.wr_stb   = ce_cpu & old_wr_n & ~cpu_wr_n_i; // first low tick only
	assign bus.rd       = ~cpu_rd_n_i;
	assign bus.addr     = cpu_addr_i;
	assign bus.wdata    = cpu_wdata_i;
	assign bus.is_gbc   = is_gbc_i;
	assign bus.cgb_mode = cgb_mode_i;

	// decode --------------------
	assign rom_hit  = ~cpu_addr_i[15];                // 0000-7fff
	assign cram_hit = cpu_addr_i[15:13] == 3'b101;    // a000-bfff
	// c000-fdff, e000 up echoes c000
	assign wram_hit = (cpu_addr_i[15:14] == 2'b11) && ~&cpu_addr_i[13:9];

	always_comb begin
		bus.sel = '0;
		bus.sel[`GB_SEL_ROM]  = rom_hit;
		bus.sel[`GB_SEL_CRAM] = cram_hit;
		bus.sel[`GB_SEL_WRAM] = wram_hit;
		bus.sel[`GB_SEL_EXT]  = rom_hit | cram_hit | wram_hit;
		bus.sel[`GB_SEL_HRAM] = (cpu_addr_i[15:7] == 9'h1ff) && (cpu_addr_i != `GB_REG_IE);
		bus.sel[`GB_SEL_IF]   = cpu_addr_i == `GB_REG_IF;
		bus.sel[`GB_SEL_IE]   = cpu_addr_i == `GB_REG_IE;
		bus.sel[`GB_SEL_JOYP] = cpu_addr_i == `GB_REG_JOYP;
		// key0 only while the boot rom runs
		bus.sel[`GB_SEL_KEY0] = is_gbc_i && boot_rom_en_i && (cpu_addr_i == `GB_REG_KEY0);
		bus.sel[`GB_SEL_KEY1] = is_gbc_i && cgb_mode_i && (cpu_addr_i == `GB_REG_KEY1);
		bus.sel[`GB_SEL_VBK]  = is_gbc_i && (cpu_addr_i == `GB_REG_VBK);
		bus.sel[`GB_SEL_SVBK] = is_gbc_i && cgb_mode_i && (cpu_addr_i == `GB_REG_SVBK);
		bus.sel[`GB_SEL_BOOT] = boot_rom_en_i && (cpu_addr_i == `GB_REG_BOOT);
		bus.sel[`GB_SEL_RP]   = is_gbc_i && cgb_mode_i && (cpu_addr_i == 16'hff56); // ir port
		// spares, ff74 hidden outside cgb mode
		bus.sel[`GB_SEL_SPARE] = is_gbc_i && (cpu_addr_i >= `GB_REG_FF72)
			&& (cpu_addr_i <= `GB_REG_FF75)
			&& ((cpu_addr_i != `GB_REG_FF74) || cgb_mode_i);
	end

	assign regs_hit = |{bus.sel[`GB_SEL_JOYP], bus.sel[`GB_SEL_KEY0], bus.sel[`GB_SEL_KEY1],
		bus.sel[`GB_SEL_VBK], bus.sel[`GB_SEL_SVBK], bus.sel[`GB_SEL_BOOT],
		bus.sel[`GB_SEL_SPARE], bus.sel[`GB_SEL_RP]};

	// read mux --------------------
	// ack vector wins over everything, unmapped reads float high
	always_comb begin
		if (irq_ack_i)
			cpu_rdata_o = irq_vec_i;
		else if (bus.sel[`GB_SEL_IF])
			cpu_rdata_o = irq_rdata_i;
		else if (regs_hit)
			cpu_rdata_o = regs_rdata_i;
		else if ((is_gbc_i && wram_hit) || bus.sel[`GB_SEL_HRAM])
			cpu_rdata_o = ram_rdata_i;   // internal wram only on cgb
		else if (bus.sel[`GB_SEL_EXT])
			cpu_rdata_o = ext_rdata_i;
		else if (bus.sel[`GB_SEL_IE])
			cpu_rdata_o = irq_rdata_i;
		else
			cpu_rdata_o = 8'hff;
	end

endmodule

/* hw/gb_defines.svh */
// widths, register addresses and select bit positions of the system bus glue
// include wherever one of these is needed
`ifndef GB_DEFINES_SVH
`define GB_DEFINES_SVH

// widths --------------------
`define GB_ADDR_W         16
`define GB_DATA_W         8
`define GB_CART_ADDR_W    15 // a15 leaves the cart port separately
`define GB_WRAM_AW        15 // 32k cgb work ram
`define GB_HRAM_AW        7
`define GB_IRQ_N          5
`define GB_OPEN_BUS_DECAY 4  // ce ticks until the bus floats to ff

// io registers --------------------
`define GB_REG_JOYP 16'hff00
`define GB_REG_IF   16'hff0f
`define GB_REG_KEY0 16'hff4c
`define GB_REG_KEY1 16'hff4d
`define GB_REG_VBK  16'hff4f
`define GB_REG_BOOT 16'hff50
`define GB_REG_SVBK 16'hff70
`define GB_REG_FF72 16'hff72
`define GB_REG_FF73 16'hff73
`define GB_REG_FF74 16'hff74
`define GB_REG_FF75 16'hff75
`define GB_REG_IE   16'hffff

// bit positions in gb_sel_t --------------------
`define GB_SEL_ROM   0
`define GB_SEL_CRAM  1
`define GB_SEL_WRAM  2
`define GB_SEL_HRAM  3
`define GB_SEL_IF    4
`define GB_SEL_IE    5
`define GB_SEL_JOYP  6
`define GB_SEL_KEY0  7
`define GB_SEL_KEY1  8
`define GB_SEL_VBK   9
`define GB_SEL_SVBK  10
`define GB_SEL_BOOT  11
`define GB_SEL_SPARE 12 // ff72-ff75 as one group
`define GB_SEL_EXT   13 // rom, cart ram or work ram
`define GB_SEL_RP    14 // highest index, sizes gb_sel_t

`endif

/* hw/gb_ext_bus.sv */
// external cartridge bus: chip select, a15, rd/wr strobes, dmg work ram
// on the same bus and the slowly decaying open bus value
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_ext_bus import gb_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset_ss,
	input  logic                       ce_i,
	gb_bus_if.dev                      bus,
	input  logic                       boot_rom_en_i,
	input  gb_data_t                   dmg_wram_rdata_i,
	input  gb_data_t                   cart_do_i,
	input  logic                       cart_oe_i,
	output logic [`GB_CART_ADDR_W-1:0] cart_addr_o,
	output logic                       cart_a15_o,
	output logic                       cart_rd_o,
	output logic                       cart_wr_o,
	output gb_data_t                   cart_di_o,
	output logic                       ncs_o,
	output logic                       dmg_wram_we_o,
	output gb_data_t                   rdata_o
);

	logic     sel_boot;   // boot rom shadows the cart here
	logic     wram_sel;
	logic     cart_sel;
	logic     dmg_wram;   // dmg work ram answers
	logic     driven;
	logic     ext_wr;
	gb_data_t ob_data;    // last byte seen on the bus
	logic [2:0] ob_cnt;   // ce ticks since the bus was driven

	// 0000-00ff, on cgb also 0200-08ff
	assign sel_boot = boot_rom_en_i && ((bus.addr[15:8] == 8'h00)
		|| (bus.is_gbc && (bus.addr[15:8] inside {[8'h02:8'h08]})));

	assign ncs_o       = ~(bus.sel[`GB_SEL_CRAM] | bus.sel[`GB_SEL_WRAM]);
	assign cart_a15_o  = bus.addr[15] | sel_boot; // stays high over boot rom
	assign cart_addr_o = bus.addr[`GB_CART_ADDR_W-1:0];
	assign cart_di_o   = bus.wdata;

	assign wram_sel = ~ncs_o & bus.addr[14];
	assign cart_sel = ~cart_a15_o | (~ncs_o & ~bus.addr[14]); // rom or cart ram
	assign ext_wr   = bus.sel[`GB_SEL_EXT] & bus.wr_stb;

	assign cart_rd_o     = cart_sel & bus.sel[`GB_SEL_EXT] & bus.rd;
	assign cart_wr_o     = cart_sel & ext_wr;
	assign dmg_wram_we_o = ~bus.is_gbc & wram_sel & ext_wr;

	assign dmg_wram = ~bus.is_gbc & wram_sel;
	assign driven   = dmg_wram | (cart_sel & cart_oe_i);
	assign rdata_o  = dmg_wram ? dmg_wram_rdata_i : (cart_sel & cart_oe_i) ? cart_do_i : ob_data;

	// open bus --------------------
	// bus capacitance holds the last byte, then pull-ups win
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ob_data <= 8'hff;
			ob_cnt  <= '0;
		end else if (ce_i) begin
			ob_data <= rdata_o;
			if (driven) begin
				ob_cnt <= '0;
			end else if (~&ob_cnt) begin
				ob_cnt <= ob_cnt + 1'b1;
				if (ob_cnt == 3'(`GB_OPEN_BUS_DECAY))
					ob_data <= 8'hff;
			end
		end
	end

	a_one_writer: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!(cart_wr_o && dmg_wram_we_o))
		else $error("cart and work ram written together");

endmodule

/* hw/gb_int_ram.sv */
// internal memories: 32k banked work ram (cgb, dmg uses banks 0/1 through
// the external bus port) and the 127 byte high ram at ff80-fffe
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_int_ram import gb_pkg::*; (
	input  logic       clk_sys,
	gb_bus_if.dev      bus,
	input  wram_bank_t wram_bank_i,
	input  logic       dmg_wram_we_i,
	output gb_data_t   rdata_o,
	output gb_data_t   dmg_wram_rdata_o
);

	gb_data_t               wram [0:(1 << `GB_WRAM_AW) - 1];
	gb_data_t               hram [0:(1 << `GB_HRAM_AW) - 2]; // ffff is ie
	wram_bank_t             bank_eff;
	logic [`GB_WRAM_AW-1:0] wram_addr;
	logic                   wram_we;
	logic                   hram_we;
	gb_data_t               wram_q;
	gb_data_t               hram_q;
	logic                   hram_rd;  // last read went to hram

	assign bank_eff = (wram_bank_i == '0) ? 3'd1 : wram_bank_i; // svbk 0 maps bank 1
	// c000-cfff bank 0, d000-dfff switchable
	assign wram_addr = bus.addr[12] ? {bank_eff, bus.addr[11:0]} : {3'd0, bus.addr[11:0]};

	assign wram_we = (bus.is_gbc & bus.sel[`GB_SEL_WRAM] & bus.wr_stb) | dmg_wram_we_i;
	assign hram_we = bus.sel[`GB_SEL_HRAM] & bus.wr_stb;

	always_ff @(posedge clk_sys) begin
		if (bus.ce_cpu) begin
			if (wram_we)
				wram[wram_addr] <= bus.wdata;
			if (hram_we)
				hram[bus.addr[`GB_HRAM_AW-1:0]] <= bus.wdata;
			wram_q  <= wram[wram_addr];
			hram_q  <= hram[bus.addr[`GB_HRAM_AW-1:0]];
			hram_rd <= bus.sel[`GB_SEL_HRAM];
		end
	end

	assign rdata_o          = hram_rd ? hram_q : wram_q;
	assign dmg_wram_rdata_o = wram_q;

endmodule

/* hw/gb_irq_ctrl.sv */
// interrupt controller: if/ie registers, source edge capture, vector of the
// lowest pending enabled source, flag clear when the cpu ack cycle ends
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_irq_ctrl import gb_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	gb_bus_if.dev      bus,
	input  logic       cpu_iorq_n_i,
	input  logic       cpu_m1_n_i,
	input  gb_irq_t    irq_src_i,
	input  logic [3:0] joy_din_i,
	output logic       irq_ack_o,
	output gb_data_t   irq_vec_o,
	output gb_data_t   rdata_o,
	output logic       cpu_irq_n_o
);

	gb_irq_t    if_r;
	gb_data_t   ie_r;    // all 8 bits r/w, 4:0 gate requests
	gb_irq_t    old_src;
	logic [3:0] joy_d1;
	logic [3:0] joy_d2;
	logic       old_ack;
	gb_irq_t    pend;    // flagged and enabled
	gb_irq_t    first;   // lowest bit of pend
	gb_irq_t    set_m;
	gb_irq_t    clr_m;

	assign irq_ack_o   = ~cpu_iorq_n_i & ~cpu_m1_n_i;
	assign pend        = if_r & ie_r[`GB_IRQ_N-1:0];
	assign first       = pend & (~pend + 1'b1);
	assign cpu_irq_n_o = ~|pend;
	assign rdata_o     = bus.sel[`GB_SEL_IF] ? {3'b111, if_r} : ie_r;

	// rising source edges, plus any falling joypad line into bit 4
	assign set_m = (irq_src_i & ~old_src)
		| {|(~joy_d1 & joy_d2), {(`GB_IRQ_N-1){1'b0}}};
	assign clr_m = (old_ack & ~irq_ack_o) ? first : '0; // end of ack

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r    <= '0;
			ie_r    <= '0;
			old_src <= '0;
			joy_d1  <= 4'hf; // lines idle high
			joy_d2  <= 4'hf;
			old_ack <= 1'b0;
		end else if (bus.ce_cpu) begin
			old_src <= irq_src_i;
			joy_d1  <= joy_din_i;
			joy_d2  <= joy_d1;
			old_ack <= irq_ack_o;
			if_r    <= (if_r | set_m) & ~clr_m;
			// cpu writes override captures on the same tick
			if (bus.wr_stb && bus.sel[`GB_SEL_IE])
				ie_r <= bus.wdata;
			if (bus.wr_stb && bus.sel[`GB_SEL_IF])
				if_r <= bus.wdata[`GB_IRQ_N-1:0];
		end
	end

	// rst 40/48/50/58/60
	always_comb begin
		irq_vec_o = 8'h00;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vec_o = 8'h40 + 8'(i * 8);
		end
	end

	a_one_clear_per_ack: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(bus.ce_cpu && old_ack && !irq_ack_o && !(bus.wr_stb && bus.sel[`GB_SEL_IF]))
		|=> $countones($past(if_r) & ~if_r) <= 1)
		else $error("ack cleared more than one flag");

endmodule

/* hw/gb_pkg.sv */
// vector types shared by the bus glue modules and the cpu bus interface
// import by wildcard in the module header
`include "gb_defines.svh"

package gb_pkg;

	typedef logic [`GB_ADDR_W-1:0] gb_addr_t; // cpu address
	typedef logic [`GB_DATA_W-1:0] gb_data_t; // bus byte

	// vblank, lcd stat, timer, serial, joypad from bit 0 up
	typedef logic [`GB_IRQ_N-1:0] gb_irq_t;

	typedef logic [2:0] wram_bank_t; // svbk, 0 acts as 1

	// one bit per decoded area or register
	typedef logic [`GB_SEL_RP:0] gb_sel_t;

endpackage

/* hw/gb_sys_regs.sv */
// system control registers: joypad select, key0/key1, vram and wram bank,
// boot rom disable at ff50 and the spare cgb registers ff72-ff75
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_sys_regs import gb_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	gb_bus_if.dev      bus,
	input  logic       ce_2x_i,
	input  logic       cpu_stop_i,
	input  logic [3:0] joy_din_i,
	output gb_data_t   rdata_o,
	output logic       speed_o,
	output logic       boot_rom_en_o,
	output logic       cgb_mode_o,
	output wram_bank_t wram_bank_o,
	output logic       vram_bank_o,
	output logic [1:0] joy_p54_o
);

	logic [1:0] key0;    // 00 cgb, 01 dmg, 1x pgb
	logic       prepare; // key1 bit 0, arms the speed switch
	gb_data_t   ff72;
	gb_data_t   ff73;
	gb_data_t   ff74;
	logic [2:0] ff75;    // only bits 6:4 exist

	assign cgb_mode_o = (key0 == 2'b00) | boot_rom_en_o;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54_o     <= 2'b00;
			key0          <= 2'b00;
			prepare       <= 1'b0;
			speed_o       <= 1'b0;
			vram_bank_o   <= 1'b0;
			wram_bank_o   <= '0;
			boot_rom_en_o <= 1'b1;
			ff72          <= '0;
			ff73          <= '0;
			ff74          <= '0;
			ff75          <= '0;
		end else begin
			if (bus.wr_stb) begin
				if (bus.sel[`GB_SEL_JOYP])
					joy_p54_o <= bus.wdata[5:4];
				if (bus.sel[`GB_SEL_KEY0])
					key0 <= bus.wdata[3:2];
				if (bus.sel[`GB_SEL_KEY1])
					prepare <= bus.wdata[0];
				if (bus.sel[`GB_SEL_VBK])
					vram_bank_o <= bus.wdata[0];
				if (bus.sel[`GB_SEL_SVBK])
					wram_bank_o <= bus.wdata[2:0];
				// 11 on cgb, any odd value on dmg unmaps the boot rom
				if (bus.sel[`GB_SEL_BOOT] && (bus.is_gbc ? bus.wdata == 8'h11 : bus.wdata[0]))
					boot_rom_en_o <= 1'b0;
				if (bus.sel[`GB_SEL_SPARE]) begin
					case (bus.addr[1:0])
						2'b10:   ff72 <= bus.wdata;
						2'b11:   ff73 <= bus.wdata;
						2'b00:   ff74 <= bus.wdata;
						default: ff75 <= bus.wdata[6:4];
					endcase
				end
			end
			// speed flips while the cpu sits in stop
			if (ce_2x_i && bus.is_gbc && prepare && cpu_stop_i) begin
				speed_o <= ~speed_o;
				prepare <= 1'b0;
			end
		end
	end

	always_comb begin
		rdata_o = 8'hff; // ff50 and unused bits read high
		if (bus.sel[`GB_SEL_JOYP])
			rdata_o = {2'b11, joy_p54_o, joy_din_i};
		else if (bus.sel[`GB_SEL_KEY0])
			rdata_o = {4'hf, key0, 2'b10};
		else if (bus.sel[`GB_SEL_KEY1])
			rdata_o = {speed_o, 6'h3f, prepare};
		else if (bus.sel[`GB_SEL_VBK])
			rdata_o = {7'h7f, vram_bank_o};
		else if (bus.sel[`GB_SEL_SVBK])
			rdata_o = {5'h1f, wram_bank_o};
		else if (bus.sel[`GB_SEL_RP])
			rdata_o = 8'h02;     // no ir light seen
		else if (bus.sel[`GB_SEL_SPARE]) begin
			case (bus.addr[1:0])
				2'b10:   rdata_o = ff72;
				2'b11:   rdata_o = ff73;
				2'b00:   rdata_o = ff74;
				default: rdata_o = {1'b1, ff75, 4'hf};
			endcase
		end
	end

	// once unmapped the boot rom stays gone until the next reset
	a_boot_stays_off: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!$rose(boot_rom_en_o))
		else $error("boot rom enable came back");

endmodule
